// File: design/yaw_pkg.sv
/*
 Shared types and constants for the yaw heading-hold stage.
 Angles are signed 1/16 degree counts, so 5760 is one full turn.
 The step enum is one-hot and doubles as the step enable bus.
*/
package yaw_pkg;

	// Heading or error, 12 integer bits and 4 fraction bits
	typedef logic signed [15:0] angle_t;

	// Raw receiver value, 0 to 255
	typedef logic [7:0] rc_value_t;

	// One receiver and IMU sample, latched together at the start of a step
	typedef struct packed {
		rc_value_t throttle;
		rc_value_t yaw_stick;
		angle_t    imu_heading;
	} rc_sample_t;

	// Published result of one control step
	typedef struct packed {
		angle_t target;
		angle_t error;
	} yaw_result_t;

	// Angle landmarks in IMU units
	localparam angle_t ANGLE_360 = 16'sd5760;
	localparam angle_t ANGLE_270 = 16'sd4320;
	localparam angle_t ANGLE_90  = 16'sd1440;

	// Throttle below this counts as idle
	localparam rc_value_t THROTTLE_IDLE = 8'd10;

	// Normalized stick magnitude below this is ignored
	localparam angle_t DEADBAND = 16'sd4;

	// Sequencer states, one bit per step
	typedef enum logic [8:0] {
		INIT      = 9'b0_0000_0001,
		IDLE_WAIT = 9'b0_0000_0010,
		LATCH     = 9'b0_0000_0100,
		SHAPE     = 9'b0_0000_1000,
		TRACK     = 9'b0_0001_0000,
		LIMIT     = 9'b0_0010_0000,
		ERROR     = 9'b0_0100_0000,
		CLAMP     = 9'b0_1000_0000,
		DONE      = 9'b1_0000_0000
	} step_e;

endpackage

// File: design/yaw_step_sequencer.sv
/*
 Paces one control step. A start is taken only in IDLE_WAIT with busy low.
 The receiver sample is captured on the accepting edge and held for the step.
 done is a registered one-cycle pulse, seven edges after start.
*/
`timescale 1ns/10ps

module yaw_step_sequencer
	import yaw_pkg::*;
(
	input  logic       us_clk,
	input  logic       resetn,
	input  logic       start,
	input  logic       imu_ready,
	input  rc_value_t  throttle,
	input  rc_value_t  yaw_stick,
	input  angle_t     imu_heading,
	output step_e      step,
	output rc_sample_t sample,
	output logic       busy,
	output logic       done
);

	step_e step_next;
	logic  accept;

	assign accept = (step == IDLE_WAIT) && start && !busy;

	// One state per step, no branching once a step is running
	always_comb begin
		step_next = step;
		case (step)
			INIT: begin
				if (imu_ready)
					step_next = IDLE_WAIT;
			end
			IDLE_WAIT: begin
				if (accept)
					step_next = LATCH;
			end
			LATCH:   step_next = SHAPE;
			SHAPE:   step_next = TRACK;
			TRACK:   step_next = LIMIT;
			LIMIT:   step_next = ERROR;
			ERROR:   step_next = CLAMP;
			CLAMP:   step_next = DONE;
			DONE:    step_next = IDLE_WAIT;
			default: step_next = INIT;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			step <= INIT;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			step <= step_next;
			// busy covers LATCH through the done pulse
			busy <= (step != INIT) && (step != IDLE_WAIT);
			done <= (step == DONE);
		end
	end

	// Raw heading goes through, glitch filtering is downstream
	always_ff @(posedge us_clk) begin
		if (accept) begin
			sample.throttle    <= throttle;
			sample.yaw_stick   <= yaw_stick;
			sample.imu_heading <= imu_heading;
		end
	end

	a_done_single: assert property (@(posedge us_clk) disable iff (!resetn)
		done |=> !done)
		else $error("done held high for more than one cycle");

endmodule

// File: design/stick_target_tracker.sv
/*
 Integrates the yaw stick into a heading target kept at 2^SCALE_BITS resolution.
 heading << SCALE_BITS must fit a signed 16-bit word, so SCALE_BITS is at most 2.
 The neutral point is only learned while the throttle is idle.
*/
`timescale 1ns/10ps

module stick_target_tracker
	import yaw_pkg::*;
#(
	parameter int SCALE_BITS = 2,
	parameter int STICK_GAIN = 4
) (
	input  logic       us_clk,
	input  logic       resetn,
	input  step_e      step,
	input  rc_sample_t sample,
	input  logic       high_gain,
	input  angle_t     heading,
	input  angle_t     prev_error,
	output angle_t     scaled_target,
	output angle_t     stick_norm,
	output logic       throttle_idle
);

	localparam angle_t SCALED_360 = angle_t'(ANGLE_360 <<< SCALE_BITS);

	rc_value_t neutral;
	angle_t    old_target;
	angle_t    stick_diff;
	angle_t    norm_next;
	angle_t    sum;
	angle_t    track_next;
	logic      outside_deadband;
	logic      freeze;

	// Stick offset from neutral, then gain
	always_comb begin
		stick_diff = angle_t'({8'd0, sample.yaw_stick}) - angle_t'({8'd0, neutral});
		if (high_gain)
			norm_next = angle_t'(stick_diff * STICK_GAIN);
		else
			norm_next = stick_diff >>> 2;
		outside_deadband = (norm_next >= DEADBAND) || (norm_next <= -DEADBAND);
	end

	// Next target for TRACK
	always_comb begin
		sum = scaled_target + norm_next;
		if (throttle_idle)
			track_next = heading <<< SCALE_BITS;
		else if (!outside_deadband)
			track_next = scaled_target;
		else if (sum > SCALED_360)
			track_next = sum - SCALED_360;
		else if (sum < 0)
			track_next = sum + SCALED_360;
		else
			track_next = sum;
	end

	// Error already pinned at the limit and stick pushing further
	assign freeze = ((prev_error >= ANGLE_90) && (stick_norm > 0)) ||
		((prev_error <= -ANGLE_90) && (stick_norm < 0));

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			scaled_target <= '0;
			old_target    <= '0;
			neutral       <= '0;
			stick_norm    <= '0;
			throttle_idle <= 1'b0;
		end else begin
			case (step)
				LATCH: begin
					throttle_idle <= (sample.throttle < THROTTLE_IDLE);
					old_target    <= scaled_target;
				end
				SHAPE: begin
					if (throttle_idle)
						neutral <= sample.yaw_stick;
				end
				TRACK: begin
					stick_norm    <= norm_next;
					scaled_target <= track_next;
				end
				LIMIT: begin
					// Drop this step's stick input
					if (freeze)
						scaled_target <= old_target;
				end
				default: ;
			endcase
		end
	end

	a_target_range: assert property (@(posedge us_clk) disable iff (!resetn)
		(scaled_target >= 0) && (scaled_target <= SCALED_360))
		else $error("scaled target left the 0 to 360 degree range");

endmodule

// File: design/imu_heading_sampler.sv
/*
 Holds the IMU heading for the current step.
 Readings outside 0 to 360 degrees are treated as glitches and skipped.
*/
`timescale 1ns/10ps

module imu_heading_sampler
	import yaw_pkg::*;
(
	input  logic       us_clk,
	input  logic       resetn,
	input  step_e      step,
	input  rc_sample_t sample,
	output angle_t     heading
);

	logic raw_valid;

	assign raw_valid = (sample.imu_heading >= 0) && (sample.imu_heading <= ANGLE_360);

	// Last valid heading is kept on a glitch
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			heading <= '0;
		else if ((step == LATCH) && raw_valid)
			heading <= sample.imu_heading;
	end

	a_heading_range: assert property (@(posedge us_clk) disable iff (!resetn)
		(heading >= 0) && (heading <= ANGLE_360))
		else $error("sampled heading out of range");

endmodule

// File: design/heading_error_unit.sv
/*
 Turns the tracked target and sampled heading into the published result.
 The error is taken the short way across the 0/360 seam and limited to +-90 degrees.
 Bypass only replaces the published values, prev_error keeps tracking.
*/
`timescale 1ns/10ps

module heading_error_unit
	import yaw_pkg::*;
#(
	parameter int SCALE_BITS = 2
) (
	input  logic        us_clk,
	input  logic        resetn,
	input  step_e       step,
	input  rc_sample_t  sample,
	input  logic        yaac_enable_n,
	input  angle_t      scaled_target,
	input  angle_t      heading,
	input  logic        throttle_idle,
	input  angle_t      stick_norm,
	output angle_t      prev_error,
	output yaw_result_t result
);

	angle_t target_q;
	angle_t raw_error;
	angle_t held_error;
	angle_t clamped_error;

	always_comb begin
		if (throttle_idle)
			raw_error = '0;
		else if ((target_q > ANGLE_270) && (heading < ANGLE_90))
			raw_error = -(ANGLE_360 - target_q + heading);
		else if ((heading > ANGLE_270) && (target_q < ANGLE_90))
			raw_error = ANGLE_360 - heading + target_q;
		else
			raw_error = target_q - heading;

		// No jump from one limit straight to the other
		if ((prev_error >= ANGLE_90) && (raw_error <= -ANGLE_90))
			held_error = ANGLE_90;
		else if ((prev_error <= -ANGLE_90) && (raw_error >= ANGLE_90))
			held_error = -ANGLE_90;
		else
			held_error = raw_error;

		if (held_error > ANGLE_90)
			clamped_error = ANGLE_90;
		else if (held_error < -ANGLE_90)
			clamped_error = -ANGLE_90;
		else
			clamped_error = held_error;
	end

	// Back to IMU resolution, idle throttle follows the IMU
	always_ff @(posedge us_clk) begin
		if (step == ERROR)
			target_q <= throttle_idle ? heading : (scaled_target >>> SCALE_BITS);
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			prev_error <= '0;
			result     <= '0;
		end else begin
			if (step == CLAMP)
				prev_error <= clamped_error;
			// Published together with the done pulse
			if (step == DONE) begin
				if (yaac_enable_n) begin
					result.target <= angle_t'({8'd0, sample.yaw_stick});
					result.error  <= '0;
				end else begin
					result.target <= target_q;
					result.error  <= prev_error;
				end
			end
		end
	end

	// Tracker freeze seen from here, the target is back to its value before TRACK
	a_freeze_holds: assert property (@(posedge us_clk) disable iff (!resetn)
		((step == ERROR) && (((prev_error >= ANGLE_90) && (stick_norm > 0)) ||
		((prev_error <= -ANGLE_90) && (stick_norm < 0))))
		|-> (scaled_target == $past(scaled_target, 4)))
		else $error("target moved while the error was pinned at the limit");

endmodule

// File: design/yaw_angle_accumulator.sv
/*
 Yaw heading-hold stage, one result per start.
 Start is ignored while busy, result must be taken when done pulses.
 SCALE_BITS above 2 overflows the 16-bit scaled target.
*/
`timescale 1ns/10ps

module yaw_angle_accumulator
	import yaw_pkg::*;
#(
	parameter int SCALE_BITS = 2,
	parameter int STICK_GAIN = 4
) (
	input  logic        us_clk,
	input  logic        resetn,
	input  logic        start,
	input  logic        imu_ready,
	input  logic        yaac_enable_n,
	input  logic        high_gain,
	input  rc_value_t   throttle,
	input  rc_value_t   yaw_stick,
	input  angle_t      imu_heading,
	output logic        busy,
	output logic        done,
	output yaw_result_t result
);

	step_e      step;
	rc_sample_t sample;
	angle_t     heading;
	angle_t     scaled_target;
	angle_t     stick_norm;
	angle_t     prev_error;
	logic       throttle_idle;

	yaw_step_sequencer u_sequencer (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.imu_ready   (imu_ready),
		.throttle    (throttle),
		.yaw_stick   (yaw_stick),
		.imu_heading (imu_heading),
		.step        (step),
		.sample      (sample),
		.busy        (busy),
		.done        (done)
	);

	// Tracker and sampler both act on LATCH
	stick_target_tracker #(
		.SCALE_BITS (SCALE_BITS),
		.STICK_GAIN (STICK_GAIN)
	) u_tracker (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.step          (step),
		.sample        (sample),
		.high_gain     (high_gain),
		.heading       (heading),
		.prev_error    (prev_error),
		.scaled_target (scaled_target),
		.stick_norm    (stick_norm),
		.throttle_idle (throttle_idle)
	);

	imu_heading_sampler u_sampler (
		.us_clk  (us_clk),
		.resetn  (resetn),
		.step    (step),
		.sample  (sample),
		.heading (heading)
	);

	heading_error_unit #(
		.SCALE_BITS (SCALE_BITS)
	) u_error (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.step          (step),
		.sample        (sample),
		.yaac_enable_n (yaac_enable_n),
		.scaled_target (scaled_target),
		.heading       (heading),
		.throttle_idle (throttle_idle),
		.stick_norm    (stick_norm),
		.prev_error    (prev_error),
		.result        (result)
	);

endmodule

// File: testbench/tb_yaw_angle_accumulator.sv
/*
 Directed tests for the yaw heading-hold stage, checked against a step-level model.
 Each control step is one start/done exchange. Results are sampled on the falling edge.
 The run is bounded at 200 clock cycles per control step.
*/
`timescale 1ns/10ps

module tb_yaw_angle_accumulator
	import yaw_pkg::*;
();

	localparam int SCALE_BITS  = 2;
	localparam int STICK_GAIN  = 4;
	localparam int SCALED_360  = 5760 << SCALE_BITS;
	// Control steps issued by all tests together
	localparam int NUM_STEPS   = 55;
	localparam int CYCLE_LIMIT = 200 * NUM_STEPS;

	logic        us_clk = 1'b0;
	logic        resetn;
	logic        start;
	logic        imu_ready;
	logic        yaac_enable_n;
	logic        high_gain;
	rc_value_t   throttle;
	rc_value_t   yaw_stick;
	angle_t      imu_heading;
	logic        busy;
	logic        done;
	yaw_result_t result;

	// Reference model state, updated once per control step
	int m_neutral;
	int m_target;
	int m_heading;
	int m_prev_error;
	int exp_target;
	int exp_error;

	int errors;
	int checks;
	int seed;
	int cycles = 0;

	yaw_angle_accumulator #(
		.SCALE_BITS (SCALE_BITS),
		.STICK_GAIN (STICK_GAIN)
	) dut (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.start         (start),
		.imu_ready     (imu_ready),
		.yaac_enable_n (yaac_enable_n),
		.high_gain     (high_gain),
		.throttle      (throttle),
		.yaw_stick     (yaw_stick),
		.imu_heading   (imu_heading),
		.busy          (busy),
		.done          (done),
		.result        (result)
	);

	always #10 us_clk = ~us_clk;

	always @(posedge us_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic int random_between(input int lo, input int hi);
		int r;
		r = $random(seed);
		r = r & 32'h7fff_ffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	task automatic check_value(input string what, input int actual, input int expected);
		checks++;
		assert (actual == expected)
			else begin
				errors++;
				$display("** Error at %0t ns: %s is %0d, expected %0d",
					$time, what, actual, expected);
			end
	endtask

	// One control step of the heading-hold rules
	task automatic model_step(input int thr, input int stick, input int imu, input bit hg,
		input bit bypass);
		int old_target;
		int diff;
		int norm;
		int sum;
		int target_deg;
		int err;
		bit idle;
		idle = thr < 10;
		old_target = m_target;
		if (imu >= 0 && imu <= 5760)
			m_heading = imu;
		if (idle)
			m_neutral = stick;
		diff = stick - m_neutral;
		norm = hg ? diff * STICK_GAIN : diff >>> 2;
		if (idle) begin
			m_target = m_heading << SCALE_BITS;
		end else if (norm >= 4 || norm <= -4) begin
			sum = m_target + norm;
			if (sum > SCALED_360)
				sum = sum - SCALED_360;
			else if (sum < 0)
				sum = sum + SCALED_360;
			m_target = sum;
		end
		if ((m_prev_error >= 1440 && norm > 0) || (m_prev_error <= -1440 && norm < 0))
			m_target = old_target;
		target_deg = idle ? m_heading : m_target >>> SCALE_BITS;
		if (idle)
			err = 0;
		else if (target_deg > 4320 && m_heading < 1440)
			err = -(5760 - target_deg + m_heading);
		else if (m_heading > 4320 && target_deg < 1440)
			err = 5760 - m_heading + target_deg;
		else
			err = target_deg - m_heading;
		// Anti-flip between the two limits
		if (m_prev_error >= 1440 && err <= -1440)
			err = 1440;
		else if (m_prev_error <= -1440 && err >= 1440)
			err = -1440;
		if (err > 1440)
			err = 1440;
		else if (err < -1440)
			err = -1440;
		m_prev_error = err;
		exp_target = bypass ? stick : target_deg;
		exp_error = bypass ? 0 : err;
	endtask

	task automatic run_step(input int thr, input int stick, input int imu, input bit hg,
		input bit bypass, input bit extra_start);
		int n;
		bit got;
		n = 0;
		got = 1'b0;
		while (busy || done)
			@(negedge us_clk);
		@(posedge us_clk);
		throttle      <= rc_value_t'(thr);
		yaw_stick     <= rc_value_t'(stick);
		imu_heading   <= angle_t'(imu);
		high_gain     <= hg;
		yaac_enable_n <= bypass;
		start         <= 1'b1;
		@(posedge us_clk);
		start <= 1'b0;
		while (!got && n < 20) begin
			@(negedge us_clk);
			// busy rises on the first edge after the accepting edge
			check_value("busy during step", int'(busy), (n > 0) ? 1 : 0);
			if (done) begin
				got = 1'b1;
			end else begin
				@(posedge us_clk);
				n++;
				// Extra start reaches the DUT on the edge after done rises while busy is high
				start <= extra_start && (n == 7);
			end
		end
		model_step(thr, stick, imu, hg, bypass);
		checks++;
		assert (got)
			else begin
				errors++;
				$display("Failure: no done pulse within 20 cycles of start at %0t ns", $time);
			end
		if (got)
			check_value("start to done latency", n, 7);
		check_value("result.target", int'(result.target), exp_target);
		check_value("result.error", int'(result.error), exp_error);
		if (extra_start) begin
			@(posedge us_clk);
			start <= 1'b0;
		end
	endtask

	task automatic check_no_done(input int span);
		int i;
		for (i = 0; i < span; i++) begin
			@(negedge us_clk);
			checks++;
			assert (!done)
				else begin
					errors++;
					$display("Failure: extra done pulse at %0t ns after a start while busy",
						$time);
				end
		end
	endtask

	task automatic idle_throttle_test();
		run_step(0, 128, 1000, 1'b0, 1'b0, 1'b0);
		run_step(100, 128, 1000, 1'b0, 1'b0, 1'b0);
		run_step(100, 148, 1010, 1'b0, 1'b0, 1'b0);
		run_step(5, random_between(100, 156), random_between(0, 5759), 1'b0, 1'b0, 1'b0);
	endtask

	task automatic deflected_stick_test();
		int i;
		run_step(0, 128, 5700, 1'b1, 1'b0, 1'b0);
		// Up through 360 in high gain, then back down through 0
		for (i = 0; i < 4; i++)
			run_step(150, 188, 5700, 1'b1, 1'b0, 1'b0);
		for (i = 0; i < 4; i++)
			run_step(150, 68, 5700, 1'b1, 1'b0, 1'b0);
		for (i = 0; i < 3; i++)
			run_step(150, random_between(160, 255), 5700, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic deadband_test();
		int i;
		run_step(0, 128, 20, 1'b0, 1'b0, 1'b0);
		run_step(120, 131, 5740, 1'b0, 1'b0, 1'b0);
		run_step(120, 121, 60, 1'b0, 1'b0, 1'b0);
		run_step(120, 128, 5700, 1'b1, 1'b0, 1'b0);
		// Heading wanders around the seam
		for (i = 0; i < 4; i++)
			run_step(120, random_between(125, 131), (5760 + random_between(-100, 140)) % 5760,
				1'b0, 1'b0, 1'b0);
	endtask

	task automatic saturation_test();
		int i;
		run_step(0, 128, 1000, 1'b1, 1'b0, 1'b0);
		// 127 units per step, limit reached after 12 steps
		for (i = 0; i < 14; i++)
			run_step(200, 255, 1000, 1'b1, 1'b0, 1'b0);
		run_step(200, 128, 4600, 1'b1, 1'b0, 1'b0);
		run_step(200, 128, 4600, 1'b1, 1'b0, 1'b0);
		run_step(200, 128, 3000, 1'b1, 1'b0, 1'b0);
		run_step(200, 128, 4600, 1'b1, 1'b0, 1'b0);
		// Negative limit with negative stick
		run_step(200, 0, 4600, 1'b1, 1'b0, 1'b0);
		run_step(200, 0, 4600, 1'b1, 1'b0, 1'b0);
		run_step(200, 255, 4600, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic imu_glitch_test();
		run_step(0, 128, 2000, 1'b0, 1'b0, 1'b0);
		run_step(0, 128, 6000, 1'b0, 1'b0, 1'b0);
		run_step(150, 128, -50, 1'b0, 1'b0, 1'b0);
		run_step(150, 128, -32768, 1'b0, 1'b0, 1'b0);
		run_step(150, 128, 2100, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic bypass_test();
		run_step(150, random_between(0, 255), 2100, 1'b0, 1'b1, 1'b0);
		run_step(150, random_between(0, 255), 2100, 1'b1, 1'b1, 1'b0);
		run_step(150, 200, 2100, 1'b0, 1'b1, 1'b1);
		check_no_done(12);
		run_step(150, 128, 2100, 1'b0, 1'b0, 1'b0);
	endtask

	initial begin
		seed          = 56;
		errors        = 0;
		checks        = 0;
		m_neutral     = 0;
		m_target      = 0;
		m_heading     = 0;
		m_prev_error  = 0;
		resetn        <= 1'b0;
		start         <= 1'b0;
		imu_ready     <= 1'b0;
		yaac_enable_n <= 1'b0;
		high_gain     <= 1'b0;
		throttle      <= '0;
		yaw_stick     <= '0;
		imu_heading   <= '0;
		repeat (2) @(posedge us_clk);
		resetn    <= 1'b1;
		imu_ready <= 1'b1;
		@(negedge us_clk);
		check_value("busy after reset", int'(busy), 0);
		check_value("done after reset", int'(done), 0);
		check_value("result after reset", int'(result), 0);
		repeat (3) @(posedge us_clk);
		idle_throttle_test();
		deflected_stick_test();
		deadband_test();
		saturation_test();
		imu_glitch_test();
		bypass_test();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: vlog.f
design/yaw_pkg.sv
design/yaw_step_sequencer.sv
design/stick_target_tracker.sv
design/imu_heading_sampler.sv
design/heading_error_unit.sv
design/yaw_angle_accumulator.sv
testbench/tb_yaw_angle_accumulator.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	--top-module tb_yaw_angle_accumulator \
	-f vlog.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
